// ==== logic/x86_flags_pkg.sv ====
// Shared types and constants for the x86 flag pipeline.
// Every RTL file refers to these by scoped name.
`default_nettype none

package x86_flags_pkg;

    // Operand width; the top-level DATA_W parameter must match it.
    parameter int DATA_W = 32;

    // EFLAGS layout, low 18 bits only.
    typedef struct packed {
        logic [8:0] rsvd_hi;  // Bits 17..9, always zero.
        logic       of;
        logic       df;
        logic [1:0] rsvd_mid; // Bits 6..5, always zero.
        logic       sf;
        logic       zf;
        logic       af;
        logic       pf;
        logic       cf;
    } eflags_t;

    // of, df, sf, zf, af, pf and cf.
    localparam logic [17:0] FLAG_DEFINED_MASK = 18'h0019F;

    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_cmp   = 4'd3,
        op_and   = 4'd4,
        op_or    = 4'd5,
        op_xor   = 4'd6,
        op_stc   = 4'd7,
        op_clc   = 4'd8,
        op_cmc   = 4'd9,
        op_std   = 4'd10,
        op_cld   = 4'd11,
        op_loadf = 4'd12  // IRET or POPF flag load from operand a.
    } flag_op_e;

    typedef struct packed {
        flag_op_e          op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              retire;
    } uop_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        eflags_t           flags;
        logic [17:0]       wmask;  // Flags this micro-op writes.
        logic              retire;
    } exec_t;

    // Debug port register offsets.
    localparam logic [3:0] REG_EFLAGS    = 4'h0;
    localparam logic [3:0] REG_COMMITTED = 4'h4;
    localparam logic [3:0] REG_RETIRED   = 4'h8;

endpackage

`default_nettype wire

// ==== logic/pipe_stage.sv ====
// Single pipeline register with a valid bit and flush.
// The payload type is set per instance.
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;  // Kill whatever is in flight.
        end else begin
            valid_q <= in_valid;
        end
    end

    // Payload only moves with a valid entry.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // A valid entry never carries unknown bits downstream.
    a_no_x_payload: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_data)
    ) else $error("pipe_stage: X payload while valid");

endmodule

`default_nettype wire

// ==== logic/flag_alu.sv ====
// Execute stage: result, new status flags and flag write mask for one micro-op.
// Purely combinational; cur_flags is the bypassed next speculative value.
`timescale 1ns/1ps
`default_nettype none

module flag_alu #(
    parameter int DATA_W = x86_flags_pkg::DATA_W
) (
    input  x86_flags_pkg::uop_t    uop,
    input  x86_flags_pkg::eflags_t cur_flags,
    output x86_flags_pkg::exec_t   result
);

    localparam int MSB = DATA_W - 1;

    // Write masks per operation class.
    localparam logic [17:0] MASK_ARITH = 18'h0011F;  // of sf zf af pf cf.
    localparam logic [17:0] MASK_LOGIC = 18'h0011B;  // af is left alone.
    localparam logic [17:0] MASK_CF    = 18'h00001;
    localparam logic [17:0] MASK_DF    = 18'h00080;

    logic [DATA_W-1:0]      a;
    logic [DATA_W-1:0]      b;
    logic [DATA_W:0]        sum;
    logic [DATA_W:0]        diff;
    logic [DATA_W-1:0]      val;
    logic [17:0]            a_ext;
    x86_flags_pkg::eflags_t flags;
    logic [17:0]            wmask;

    assign a     = uop.a;
    assign b     = uop.b;
    assign sum   = {1'b0, a} + {1'b0, b};
    assign diff  = {1'b0, a} - {1'b0, b};  // Top bit is the borrow.
    assign a_ext = 18'(a);

    // Value the sf, zf and pf flags are taken from.
    always_comb begin
        case (uop.op)
            x86_flags_pkg::op_add: val = sum[MSB:0];
            x86_flags_pkg::op_sub,
            x86_flags_pkg::op_cmp: val = diff[MSB:0];
            x86_flags_pkg::op_and: val = a & b;
            x86_flags_pkg::op_or:  val = a | b;
            x86_flags_pkg::op_xor: val = a ^ b;
            default:               val = a;
        endcase
    end

    always_comb begin
        flags    = cur_flags;
        flags.sf = val[MSB];
        flags.zf = (val == '0);
        flags.pf = ~^val[7:0];  // Even parity of the low byte.
        wmask    = '0;
        case (uop.op)
            x86_flags_pkg::op_add: begin
                flags.cf = sum[DATA_W];
                flags.of = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
                flags.af = a[4] ^ b[4] ^ sum[4];
                wmask    = MASK_ARITH;
            end
            x86_flags_pkg::op_sub,
            x86_flags_pkg::op_cmp: begin
                flags.cf = diff[DATA_W];
                flags.of = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
                flags.af = a[4] ^ b[4] ^ diff[4];
                wmask    = MASK_ARITH;
            end
            x86_flags_pkg::op_and,
            x86_flags_pkg::op_or,
            x86_flags_pkg::op_xor: begin
                flags.cf = 1'b0;
                flags.of = 1'b0;
                wmask    = MASK_LOGIC;
            end
            x86_flags_pkg::op_stc: begin
                flags.cf = 1'b1;
                wmask    = MASK_CF;
            end
            x86_flags_pkg::op_clc: begin
                flags.cf = 1'b0;
                wmask    = MASK_CF;
            end
            x86_flags_pkg::op_cmc: begin
                flags.cf = ~cur_flags.cf;
                wmask    = MASK_CF;
            end
            x86_flags_pkg::op_std: begin
                flags.df = 1'b1;
                wmask    = MASK_DF;
            end
            x86_flags_pkg::op_cld: begin
                flags.df = 1'b0;
                wmask    = MASK_DF;
            end
            x86_flags_pkg::op_loadf: begin
                // Whole flag image comes from operand a, as on IRET.
                flags = x86_flags_pkg::eflags_t'(a_ext & x86_flags_pkg::FLAG_DEFINED_MASK);
                wmask = x86_flags_pkg::FLAG_DEFINED_MASK;
            end
            default: begin
                wmask = '0;  // op_nop writes nothing.
            end
        endcase
    end

    assign result.data   = (uop.op == x86_flags_pkg::op_cmp) ? a : val;
    assign result.flags  = x86_flags_pkg::eflags_t'(flags & x86_flags_pkg::FLAG_DEFINED_MASK);
    assign result.wmask  = wmask;
    assign result.retire = uop.retire;

endmodule

`default_nettype wire

// ==== logic/eflags_reg.sv ====
// Speculative and committed EFLAGS copies.
// Merges writeback flags under the write mask, restores on resteer, takes debug writes.
`timescale 1ns/1ps
`default_nettype none

module eflags_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_valid,
    input  x86_flags_pkg::exec_t   wb,
    input  logic                   resteer,
    input  logic                   dbg_wr_en,
    input  x86_flags_pkg::eflags_t dbg_wr_data,
    output x86_flags_pkg::eflags_t cur_flags,
    output x86_flags_pkg::eflags_t committed,
    output x86_flags_pkg::eflags_t eflags_next,
    output logic                   retire_pulse
);

    localparam logic [17:0] DEF_MASK = x86_flags_pkg::FLAG_DEFINED_MASK;

    x86_flags_pkg::eflags_t spec_q;
    x86_flags_pkg::eflags_t comm_q;
    x86_flags_pkg::eflags_t merged;
    x86_flags_pkg::eflags_t spec_d;
    logic                   retire_en;

    // Only the flags named in the mask come from the writeback.
    assign merged = x86_flags_pkg::eflags_t'((spec_q & ~wb.wmask) | (wb.flags & wb.wmask));

    always_comb begin
        if (dbg_wr_en) begin
            spec_d = x86_flags_pkg::eflags_t'(dbg_wr_data & DEF_MASK);
        end else if (resteer) begin
            spec_d = comm_q;  // Writeback in this cycle is dropped.
        end else if (wb_valid) begin
            spec_d = merged;
        end else begin
            spec_d = spec_q;
        end
    end

    // A writeback squashed by resteer does not retire.
    assign retire_en = wb_valid && wb.retire && !resteer;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_q <= '0;
            comm_q <= '0;
        end else begin
            spec_q <= spec_d;
            if (dbg_wr_en || retire_en) begin
                comm_q <= spec_d;
            end
        end
    end

    assign cur_flags    = spec_q;
    assign committed    = comm_q;
    assign eflags_next  = spec_d;
    assign retire_pulse = retire_en;

    a_rsvd_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((spec_q & ~DEF_MASK) == '0) && ((comm_q & ~DEF_MASK) == '0)
    ) else $error("eflags_reg: reserved flag bit set");

endmodule

`default_nettype wire

// ==== logic/flag_apb_port.sv ====
// APB debug slave: flag readback, flag write and a retire counter.
// Zero wait states, so every access phase completes at once.
`timescale 1ns/1ps
`default_nettype none

module flag_apb_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  x86_flags_pkg::eflags_t cur_flags,
    input  x86_flags_pkg::eflags_t committed,
    input  logic                   retire_pulse,
    output logic                   dbg_wr_en,
    output x86_flags_pkg::eflags_t dbg_wr_data
);

    logic        access;
    logic        addr_ok;
    logic [15:0] retired_q;

    assign access  = psel && penable;
    assign addr_ok = (paddr == x86_flags_pkg::REG_EFLAGS) ||
                     (paddr == x86_flags_pkg::REG_COMMITTED) ||
                     (paddr == x86_flags_pkg::REG_RETIRED);

    assign pready  = 1'b1;
    // The committed copy is read only.
    assign pslverr = access && (!addr_ok ||
                     (pwrite && paddr == x86_flags_pkg::REG_COMMITTED));

    assign dbg_wr_en   = access && pwrite && (paddr == x86_flags_pkg::REG_EFLAGS);
    assign dbg_wr_data = x86_flags_pkg::eflags_t'(pwdata[17:0] &
                                                  x86_flags_pkg::FLAG_DEFINED_MASK);

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                x86_flags_pkg::REG_EFLAGS:    prdata = {14'd0, cur_flags};
                x86_flags_pkg::REG_COMMITTED: prdata = {14'd0, committed};
                x86_flags_pkg::REG_RETIRED:   prdata = {16'd0, retired_q};
                default:                      prdata = '0;
            endcase
        end
    end

    // Wrapping count of retired micro-ops.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_q <= '0;
        end else if (access && pwrite && paddr == x86_flags_pkg::REG_RETIRED) begin
            retired_q <= '0;  // Any write clears.
        end else if (retire_pulse) begin
            retired_q <= retired_q + 16'd1;
        end
    end

    a_penable_in_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    ) else $error("flag_apb_port: penable without psel");

endmodule

`default_nettype wire

// ==== logic/flag_pipe_top.sv ====
// Flag pipeline top: issue register, execute, writeback register, EFLAGS and APB port.
// Results leave the writeback register; res_flags shows the value being latched.
`timescale 1ns/1ps
`default_nettype none

module flag_pipe_top #(
    parameter int DATA_W = x86_flags_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  x86_flags_pkg::uop_t    in_uop,
    input  logic                   resteer,
    output logic                   res_valid,
    output logic [DATA_W-1:0]      res_data,
    output x86_flags_pkg::eflags_t res_flags,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic                   iss_valid;
    x86_flags_pkg::uop_t    iss_uop;
    x86_flags_pkg::exec_t   ex_res;
    logic                   wb_valid;
    x86_flags_pkg::exec_t   wb;
    x86_flags_pkg::eflags_t cur_flags;
    x86_flags_pkg::eflags_t committed;
    x86_flags_pkg::eflags_t eflags_next;
    logic                   retire_pulse;
    logic                   dbg_wr_en;
    x86_flags_pkg::eflags_t dbg_wr_data;

    pipe_stage #(.payload_t(x86_flags_pkg::uop_t)) i_issue (
        .clk(clk), .rst_n(rst_n), .flush(resteer),
        .in_valid(in_valid), .in_data(in_uop),
        .out_valid(iss_valid), .out_data(iss_uop)
    );

    // Execute sees the flags about to be latched by the older micro-op.
    flag_alu #(.DATA_W(DATA_W)) i_alu (
        .uop(iss_uop), .cur_flags(eflags_next), .result(ex_res)
    );

    pipe_stage #(.payload_t(x86_flags_pkg::exec_t)) i_wb (
        .clk(clk), .rst_n(rst_n), .flush(resteer),
        .in_valid(iss_valid), .in_data(ex_res),
        .out_valid(wb_valid), .out_data(wb)
    );

    eflags_reg i_eflags (
        .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb(wb), .resteer(resteer),
        .dbg_wr_en(dbg_wr_en), .dbg_wr_data(dbg_wr_data), .cur_flags(cur_flags),
        .committed(committed), .eflags_next(eflags_next), .retire_pulse(retire_pulse)
    );

    flag_apb_port i_apb (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .cur_flags(cur_flags), .committed(committed),
        .retire_pulse(retire_pulse), .dbg_wr_en(dbg_wr_en), .dbg_wr_data(dbg_wr_data)
    );

    assign res_valid = wb_valid;
    assign res_data  = wb.data;
    assign res_flags = eflags_next;

endmodule

`default_nettype wire

// ==== verification/tb_flag_pipe.sv ====
// Testbench for the flag pipeline. Replays verification/flag_pipe_input.txt against the DUT
// and checks results, flags and APB reads against the hand-computed values in that file.
`timescale 1ns/1ps
`default_nettype none

module tb_flag_pipe;

    typedef struct packed {
        logic [31:0] data;
        logic [17:0] flags;
    } result_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    x86_flags_pkg::uop_t    in_uop;
    logic                   resteer;
    logic                   res_valid;
    logic [31:0]            res_data;
    x86_flags_pkg::eflags_t res_flags;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [3:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    result_t     exp_q[$];  // Results still owed by the DUT, oldest first.
    result_t     got_exp;
    string       lines[$];
    string       line;
    string       cmd;
    int          fd;
    int          tnum;
    int          cur_test = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;

    flag_pipe_top #(.DATA_W(x86_flags_pkg::DATA_W)) i_dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_uop(in_uop), .resteer(resteer),
        .res_valid(res_valid), .res_data(res_data), .res_flags(res_flags),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;  // 40 ns period.

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at time %0t: %s", $time, msg);
            errors++;
            test_errors++;
        end
    endtask

    // Only three registers are mapped, and the committed copy is read only.
    function automatic logic access_error(input logic [3:0] addr, input logic write);
        if (addr != x86_flags_pkg::REG_EFLAGS && addr != x86_flags_pkg::REG_COMMITTED &&
            addr != x86_flags_pkg::REG_RETIRED) begin
            return 1'b1;
        end
        return write && (addr == x86_flags_pkg::REG_COMMITTED);
    endfunction

    // Wait until every issued micro-op has written back and its flags are latched.
    task automatic drain();
        if (exp_q.size() != 0) begin
            while (exp_q.size() != 0) @(posedge clk);
            #2;
        end
    endtask

    task automatic issue_uop(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                             input logic retire);
        in_uop.op     = x86_flags_pkg::flag_op_e'(op);
        in_uop.a      = a;
        in_uop.b      = b;
        in_uop.retire = retire;
        in_valid      = 1'b1;
        @(posedge clk);
        #2;
        in_valid = 1'b0;  // Next uop command re-asserts it in the same step.
    endtask

    task automatic pulse_resteer();
        resteer = 1'b1;
        @(posedge clk);
        #2;
        resteer = 1'b0;
    endtask

    // For a read, data is the expected value; for a write, it goes out on pwdata.
    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] data);
        drain();
        psel   = 1'b1;  // Setup phase.
        pwrite = write;
        paddr  = addr;
        pwdata = write ? data : 32'd0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        check(pslverr == access_error(addr, write),
              $sformatf("pslverr %b for address %h", pslverr, addr));
        if (!write) begin
            check(prdata == data, $sformatf("read %h from %h, expected %h", prdata, addr, data));
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic end_test();
        drain();
        if (test_errors == 0) begin
            $display("Test %0d passed", cur_test);
        end else begin
            $display("Test %0d failed with %0d errors", cur_test, test_errors);
        end
        tests++;
        test_errors = 0;
    endtask

    // Results are stable mid-cycle, well away from both clock edges.
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("Unexpected result %h at time %0t with no micro-op pending",
                         res_data, $time);
                errors++;
                test_errors++;
            end
            if (exp_q.size() != 0) begin
                got_exp = exp_q.pop_front();
                check(res_data == got_exp.data && res_flags == got_exp.flags,
                      $sformatf("result %h flags %h, expected %h flags %h",
                                res_data, res_flags, got_exp.data, got_exp.flags));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_uop   = '0;
        resteer  = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'h0;
        pwdata   = 32'd0;
        fd = $fopen("verification/flag_pipe_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/flag_pipe_input.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = lines.size() * 8 + 50;
            repeat (2) @(posedge clk);
            #2;
            rst_n = 1'b1;
            foreach (lines[i]) begin
                line = lines[i];
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                void'($sscanf(line, "%d %s %h %h %h %h", tnum, cmd, v0, v1, v2, v3));
                if (tnum != cur_test) begin
                    if (cur_test != 0) begin
                        end_test();
                    end
                    cur_test = tnum;
                end
                if (cmd == "uop") begin
                    issue_uop(v0[3:0], v1, v2, v3[0]);
                end else if (cmd == "expect") begin
                    exp_q.push_back(result_t'{data: v0, flags: v1[17:0]});
                end else if (cmd == "apb_wr") begin
                    apb_access(1'b1, v0[3:0], v1);
                end else if (cmd == "apb_rd") begin
                    apb_access(1'b0, v0[3:0], v1);
                end else if (cmd == "resteer") begin
                    pulse_resteer();
                end else begin
                    $display("Unknown command %s on line %0d of the stimulus file", cmd, i + 1);
                    errors++;
                end
            end
            if (cur_test != 0) begin
                end_test();
            end
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/flag_pipe_input.txt ====
# Columns: test number, command, then hex arguments.
# uop op a b retire | expect data flags | apb_wr addr data | apb_rd addr data | resteer
1 uop 1 ffffffff 00000001 1
1 expect 00000000 00f
1 uop 1 7fffffff 00000001 1
1 expect 80000000 116
1 uop 3 00000010 00000020 1
1 expect 00000010 013
1 uop 2 00000000 00000001 1
1 expect ffffffff 017
2 uop 4 000000f0 0000003c 1
2 expect 00000030 006
2 uop 1 7fffffff 00000001 1
2 expect 80000000 116
2 uop 5 80000000 00000001 1
2 expect 80000001 014
3 uop 7 00000000 00000000 1
3 expect 00000000 015
3 uop a 00000000 00000000 1
3 expect 00000000 095
3 uop 9 00000000 00000000 1
3 expect 00000000 094
3 uop 0 00001234 00000000 1
3 expect 00001234 094
3 uop b 00000000 00000000 1
3 expect 00000000 014
4 uop c ffffffff 00000000 1
4 expect ffffffff 19f
4 apb_rd 0 0000019f
4 uop c 00000a55 00000000 0
4 expect 00000a55 015
4 apb_rd 4 0000019f
5 uop a 00000000 00000000 1
5 expect 00000000 095
5 uop 2 00000005 00000005 0
5 expect 00000000 08a
5 apb_rd 0 0000008a
5 uop 7 00000000 00000000 1
5 resteer
5 apb_rd 0 00000095
5 apb_rd 4 00000095
6 apb_wr 0 fffe0084
6 apb_rd 0 00000084
6 apb_rd 4 00000084
6 apb_wr 8 00000000
6 uop 7 00000000 00000000 1
6 expect 00000000 085
6 uop 8 00000000 00000000 0
6 expect 00000000 084
6 apb_rd 8 00000001
6 apb_rd c 00000000

// ==== flag_pipe.f ====
logic/x86_flags_pkg.sv
logic/pipe_stage.sv
logic/flag_alu.sv
logic/eflags_reg.sv
logic/flag_apb_port.sv
logic/flag_pipe_top.sv
verification/tb_flag_pipe.sv

// ==== Makefile ====
TOP := tb_flag_pipe
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f flag_pipe.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f flag_pipe.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
